// ==== bpmFrontEnd.f ====
+incdir+verilog
verilog/bpmPkg.sv
verilog/sampleIntake.sv
verilog/demodMixer.sv
verilog/turnAccumulator.sv
verilog/magnitudeEstimator.sv
verilog/gainTrim.sv
verilog/bpmFrontEnd.sv
tests/bpmChecker.sv
tests/tbBpmFrontEnd.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds and runs the BPM front end testbench with Verilator.
# Exits nonzero when the build, the run or the log check fails.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tbBpmFrontEnd \
    -f bpmFrontEnd.f -o simBpm
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simBpm > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== tests/bpmChecker.sv ====
/*
 * Reference model and output comparison for the BPM front end.
 * Configuration is read when a turn's last sample is accepted.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module bpmChecker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  bpmPkg::adcSample     inSample [`BPM_CHANNELS],
    input  logic                 inUse [`BPM_CHANNELS],
    input  logic                 inReady,
    input  logic                 useRms,
    input  bpmPkg::sumShiftValue sumShift,
    input  bpmPkg::gainValue     gain [`BPM_CHANNELS],
    input  logic                 outValid,
    input  bpmPkg::magnitude     outMag [`BPM_CHANNELS],
    input  logic                 outOverflow,
    input  logic                 outReady,
    output int                   errorCount,
    output int                   resultCount,
    output int                   pending,
    output logic                 stalled
);
    timeunit 1ns;
    timeprecision 1ps;
    import bpmPkg::*;

    localparam longint SUM_MAX  = (longint'(1) <<< (`BPM_MAG_WIDTH - 1)) - 1;
    localparam longint MAG_MAX  = (longint'(1) <<< `BPM_MAG_WIDTH) - 1;
    localparam longint ADC_MIN  = -(longint'(1) <<< (`BPM_ADC_WIDTH - 1));
    localparam int     WATCHDOG = 200;

    longint   accI [`BPM_CHANNELS];
    longint   accQ [`BPM_CHANNELS];
    magnitude expMag [$];
    logic     expOverflow [$];
    int       position = 0;
    int       idleCycles = 0;
    int       errors = 0;
    int       results = 0;
    int       queued = 0;
    logic     tripped = 1'b0;

    assign errorCount  = errors;
    assign resultCount = results;
    assign pending     = queued;
    assign stalled     = tripped;

    function automatic longint limit(input longint value, input longint low,
            input longint high);
        if (value > high) begin
            return high;
        end else if (value < low) begin
            return low;
        end
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model of one turn

    task automatic absorbSample();
        longint sample;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            sample = longint'(inSample[k]);
            if (useRms) begin
                // Negative full scale is squared against -2047
                if (inUse[k]) begin
                    accI[k] += sample * ((sample == ADC_MIN) ? ADC_MIN + 1 : sample);
                end
            end else begin
                accI[k] += sample * longint'(LO_COS[position]);
                accQ[k] += sample * longint'(LO_SIN[position]);
            end
        end
        position++;
    endtask

    task automatic closeTurn();
        longint sI;
        longint sQ;
        longint est;
        longint trimmed;
        logic   ovf;
        ovf = 1'b0;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            sI = accI[k] >>> sumShift;
            sQ = accQ[k] >>> sumShift;
            if (sI > SUM_MAX || sI < -SUM_MAX - 1 || sQ > SUM_MAX || sQ < -SUM_MAX - 1) begin
                ovf = 1'b1;
            end
            sI = limit(sI, -SUM_MAX - 1, SUM_MAX);
            sQ = limit(sQ, -SUM_MAX - 1, SUM_MAX);
            sI = (sI < 0) ? -sI : sI;
            sQ = (sQ < 0) ? -sQ : sQ;
            est = (sI >= sQ) ? sI + (sQ >>> 1) : sQ + (sI >>> 1);
            if (est > MAG_MAX) begin
                ovf = 1'b1;
                est = MAG_MAX;
            end
            trimmed = (est * longint'(gain[k])) >>> `BPM_GAIN_FRAC;
            if (trimmed > MAG_MAX) begin
                ovf = 1'b1;
                trimmed = MAG_MAX;
            end
            expMag.push_back(magnitude'(trimmed));
            accI[k] = 0;
            accQ[k] = 0;
        end
        expOverflow.push_back(ovf);
        queued++;
        position = 0;
    endtask

    task automatic compareOutput();
        magnitude want;
        logic     flag;
        if (queued == 0) begin
            $display("output arrived with no expected result pending");
            errors++;
        end else begin
            flag = expOverflow.pop_front();
            for (int k = 0; k < `BPM_CHANNELS; k++) begin
                want = expMag.pop_front();
                if (outMag[k] !== want) begin
                    $display("MISMATCH outMag[%0d] result %0d got %h expected %h",
                        k, results, outMag[k], want);
                    errors++;
                end
            end
            if (outOverflow !== flag) begin
                $display("MISMATCH outOverflow result %0d got %h expected %h",
                    results, outOverflow, flag);
                errors++;
            end
            results++;
            queued--;
        end
    endtask

    initial begin
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            accI[k] = 0;
            accQ[k] = 0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            // Turns still in the pipeline are lost with it
            position   = 0;
            idleCycles = 0;
            queued     = 0;
            expMag.delete();
            expOverflow.delete();
            for (int k = 0; k < `BPM_CHANNELS; k++) begin
                accI[k] = 0;
                accQ[k] = 0;
            end
        end else begin
            if (inValid && inReady) begin
                absorbSample();
                if (position == `BPM_SAMPLES_PER_TURN) begin
                    closeTurn();
                end
            end
            if (outValid && outReady) begin
                compareOutput();
                idleCycles = 0;
            end else if (queued > 0) begin
                idleCycles++;
            end else begin
                idleCycles = 0;
            end
            if (idleCycles == WATCHDOG && !tripped) begin
                $display("no output within %0d cycles of an expected result", WATCHDOG);
                errors++;
                tripped = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tbBpmFrontEnd.sv ====
/*
 * Testbench for the BPM front end. Stimulus comes from an LCG with a fixed seed.
 * Configuration only changes while the pipeline is empty.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module tbBpmFrontEnd;
    timeunit 1ns;
    timeprecision 1ps;
    import bpmPkg::*;

    // 5 tests x 40 turns x 8 samples x 4 stall factor, rounded up
    localparam int TIMEOUT_CYCLES = 8000;
    localparam int UNITY = 1 << `BPM_GAIN_FRAC;

    logic         clk = 1'b0;
    logic         reset;
    logic         inValid;
    adcSample     inSample [`BPM_CHANNELS];
    logic         inUse [`BPM_CHANNELS];
    logic         inReady;
    logic         useRms;
    sumShiftValue sumShift;
    gainValue     gain [`BPM_CHANNELS];
    logic         outValid;
    magnitude     outMag [`BPM_CHANNELS];
    logic         outOverflow;
    logic         outReady;

    int          checkErrors;
    int          checkResults;
    int          pending;
    logic        stalled;
    logic        taken = 1'b0;
    int          cycles = 0;
    int          resetErrors;
    int          testCount;
    int          markErrors;
    int          markResults;
    int          totalErrors;
    logic [31:0] seed;

    bpmFrontEnd i_dut (.clk, .reset, .inValid, .inSample, .inUse, .inReady, .useRms,
        .sumShift, .gain, .outValid, .outMag, .outOverflow, .outReady);

    bpmChecker outputCheck (.clk, .reset, .inValid, .inSample, .inUse, .inReady,
        .useRms, .sumShift, .gain, .outValid, .outMag, .outOverflow, .outReady,
        .errorCount(checkErrors), .resultCount(checkResults), .pending,
        .stalled);

    always #50 clk = ~clk;

    // Input transfer on the edge just passed
    always @(posedge clk) taken <= inValid && inReady;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int randBelow(input int limit);
        logic [31:0] value;
        value = nextRand();
        return int'({1'b0, value[31:8]}) % limit;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks

    task automatic configure(input logic rms, input int shift, input logic randomGain);
        @(negedge clk);
        useRms   = rms;
        sumShift = sumShiftValue'(shift);
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            gain[k] = randomGain ? gainValue'(randBelow(2 * UNITY + 1)) : gainValue'(UNITY);
        end
    endtask

    // Mode 1 gives near full-scale samples of either sign
    task automatic fillSample(input int mode);
        int level;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            if (mode == 1) begin
                level = 2040 + randBelow(9);
                inSample[k] = adcSample'((randBelow(2) == 1) ? -level : level);
            end else begin
                inSample[k] = adcSample'(nextRand() >> 20);
            end
            inUse[k] = (randBelow(2) == 1);
        end
    endtask

    task automatic runTraffic(input int turns, input int gapPct, input int stallPct,
            input int mode);
        int sent;
        sent = 0;
        while (sent < turns * `BPM_SAMPLES_PER_TURN) begin
            @(negedge clk);
            if (taken) begin
                sent++;
            end
            outReady = (randBelow(100) >= stallPct);
            if (inValid && !taken) begin
                // Offered sample still waiting, hold it
            end else if (sent < turns * `BPM_SAMPLES_PER_TURN &&
                    randBelow(100) >= gapPct) begin
                inValid = 1'b1;
                fillSample(mode);
            end else begin
                inValid = 1'b0;
            end
        end
    endtask

    task automatic drainPipeline(input int stallPct);
        inValid = 1'b0;
        while (pending != 0 && !stalled) begin
            @(negedge clk);
            outReady = (randBelow(100) >= stallPct);
        end
        @(negedge clk);
        outReady = 1'b1;
    endtask

    task automatic markStart();
        markErrors  = checkErrors + resetErrors;
        markResults = checkResults;
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("test %0d %s: %0d results checked, %0d errors", testCount, name,
            checkResults - markResults, checkErrors + resetErrors - markErrors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed        = 32'd83722;
        reset       = 1'b1;
        inValid     = 1'b0;
        outReady    = 1'b1;
        useRms      = 1'b0;
        sumShift    = '0;
        resetErrors = 0;
        testCount   = 0;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            inSample[k] = '0;
            inUse[k]    = 1'b0;
            gain[k]     = gainValue'(UNITY);
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        markStart();
        configure(1'b0, 2, 1'b0);
        runTraffic(40, 0, 0, 0);
        drainPipeline(0);
        endTest("demodulation");

        markStart();
        configure(1'b1, 3, 1'b0);
        runTraffic(40, 0, 0, 0);
        drainPipeline(0);
        endTest("rms");

        markStart();
        configure(1'b0, 0, 1'b0);
        runTraffic(40, 0, 0, 1);
        drainPipeline(0);
        endTest("saturation");

        // New gains every ten turns
        markStart();
        for (int round = 0; round < 4; round++) begin
            configure(1'b0, 1, 1'b1);
            runTraffic(10, 0, 0, 1);
            drainPipeline(0);
        end
        endTest("trim");

        markStart();
        configure(1'b0, 3, 1'b0);
        runTraffic(40, 30, 50, 0);
        drainPipeline(50);
        endTest("back-pressure");

        // Output held back, so results wait in every stage
        markStart();
        configure(1'b0, 2, 1'b0);
        runTraffic(4, 0, 100, 0);
        // First sample of a fifth turn fills the intake behind the stall
        fillSample(0);
        @(negedge clk);
        inValid = 1'b0;
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (outValid || !inReady) begin
                $display("outValid high or inReady low after reset with no input");
                resetErrors++;
            end
        end
        // Turn position starts over after reset
        runTraffic(2, 0, 0, 0);
        drainPipeline(0);
        endTest("reset");

        totalErrors = checkErrors + resetErrors;
        $display("tests %0d, results checked %0d, errors %0d", testCount, checkResults,
            totalErrors);
        if (totalErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/bpmFrontEnd.sv ====
/*
 * Four-channel turn-by-turn BPM front end, one result per turn of eight
 * samples. Configuration inputs may only change while the pipeline is empty.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module bpmFrontEnd (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  bpmPkg::adcSample     inSample [`BPM_CHANNELS],
    input  logic                 inUse [`BPM_CHANNELS],
    output logic                 inReady,
    input  logic                 useRms,
    input  bpmPkg::sumShiftValue sumShift,
    input  bpmPkg::gainValue     gain [`BPM_CHANNELS],
    output logic                 outValid,
    output bpmPkg::magnitude     outMag [`BPM_CHANNELS],
    output logic                 outOverflow,
    input  logic                 outReady
);
    import bpmPkg::*;

    //////////////////////////////////////////////////////////////////////
    // Stage links

    logic     mixValid, mixReady;
    adcSample mixSample [`BPM_CHANNELS];
    logic     mixUse [`BPM_CHANNELS];
    turnPos   mixPos;

    logic     prodValid, prodReady, prodLast;
    product   prodI [`BPM_CHANNELS];
    product   prodQ [`BPM_CHANNELS];

    logic     sumValid, sumReady, sumOverflow;
    turnSum   sumI [`BPM_CHANNELS];
    turnSum   sumQ [`BPM_CHANNELS];

    logic     magValid, magReady, magOverflow;
    magnitude mag [`BPM_CHANNELS];

    //////////////////////////////////////////////////////////////////////
    // Pipeline

    sampleIntake intake (.clk, .reset, .inValid, .inSample, .inUse, .inReady,
        .mixValid, .mixSample, .mixUse, .mixPos, .mixReady);

    demodMixer mixer (.clk, .reset, .mixValid, .mixSample, .mixUse, .mixPos,
        .useRms, .mixReady, .prodValid, .prodI, .prodQ, .prodLast, .prodReady);

    turnAccumulator accumulator (.clk, .reset, .prodValid, .prodI, .prodQ,
        .prodLast, .sumShift, .prodReady, .sumValid, .sumI, .sumQ,
        .sumOverflow, .sumReady);

    magnitudeEstimator estimator (.clk, .reset, .sumValid, .sumI, .sumQ,
        .sumOverflow, .sumReady, .magValid, .mag, .magOverflow, .magReady);

    gainTrim trim (.clk, .reset, .magValid, .mag, .magOverflow, .gain,
        .magReady, .outValid, .outMag, .outOverflow, .outReady);

endmodule

`default_nettype wire

// ==== verilog/bpmPkg.sv ====
/*
 * Shared data types and the fixed LO tables of the front end.
 * LO entries never reach negative full scale.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

package bpmPkg;

    // Data path words
    typedef logic signed [`BPM_ADC_WIDTH-1:0]     adcSample;
    typedef logic signed [`BPM_LO_WIDTH-1:0]      loValue;
    typedef logic signed [`BPM_PRODUCT_WIDTH-1:0] product;
    typedef logic signed [`BPM_MAG_WIDTH-1:0]     turnSum;
    typedef logic [`BPM_MAG_WIDTH-1:0]            magnitude;

    // Configuration and bookkeeping
    typedef logic [`BPM_GAIN_WIDTH-1:0]                gainValue;
    typedef logic [`BPM_SHIFT_WIDTH-1:0]               sumShiftValue;
    typedef logic [$clog2(`BPM_SAMPLES_PER_TURN)-1:0]  turnPos;

    // One LO period per turn, round(2047 * cos/sin(2 pi k / 8))
    localparam loValue LO_COS [`BPM_SAMPLES_PER_TURN] = '{
        loValue'(2047), loValue'(1447), loValue'(0), loValue'(-1447),
        loValue'(-2047), loValue'(-1447), loValue'(0), loValue'(1447)
    };

    localparam loValue LO_SIN [`BPM_SAMPLES_PER_TURN] = '{
        loValue'(0), loValue'(1447), loValue'(2047), loValue'(1447),
        loValue'(0), loValue'(-1447), loValue'(-2047), loValue'(-1447)
    };

endpackage

`default_nettype wire

// ==== verilog/bpmSettings_settings.svh ====
/*
 * Sizes of the front end. The LO table length equals the samples per turn,
 * which must be a power of two. The product width is ADC plus LO width minus one.
 */
`ifndef BPM_SETTINGS_SVH
`define BPM_SETTINGS_SVH

// Channels and turn structure
`define BPM_CHANNELS          4
`define BPM_SAMPLES_PER_TURN  8

// Data path widths
`define BPM_ADC_WIDTH         12
`define BPM_LO_WIDTH          12
`define BPM_PRODUCT_WIDTH     23
`define BPM_ACC_WIDTH         32
`define BPM_MAG_WIDTH         24
`define BPM_GAIN_WIDTH        16
`define BPM_GAIN_FRAC         14
`define BPM_SHIFT_WIDTH       4

`endif

// ==== verilog/demodMixer.sv ====
/*
 * Mixer stage. useRms must only change while the pipeline is empty.
 * In RMS mode a negative full-scale sample is squared as -2048 * -2047.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module demodMixer (
    input  logic             clk,
    input  logic             reset,
    input  logic             mixValid,
    input  bpmPkg::adcSample mixSample [`BPM_CHANNELS],
    input  logic             mixUse [`BPM_CHANNELS],
    input  bpmPkg::turnPos   mixPos,
    input  logic             useRms,
    output logic             mixReady,
    output logic             prodValid,
    output bpmPkg::product   prodI [`BPM_CHANNELS],
    output bpmPkg::product   prodQ [`BPM_CHANNELS],
    output logic             prodLast,
    input  logic             prodReady
);
    import bpmPkg::*;

    localparam adcSample ADC_NEG_FULL = {1'b1, {(`BPM_ADC_WIDTH-1){1'b0}}};

    product nextI [`BPM_CHANNELS];
    product nextQ [`BPM_CHANNELS];
    loValue rmsLo [`BPM_CHANNELS];
    logic   accept;

    assign mixReady = !prodValid || prodReady;
    assign accept   = mixValid && mixReady;

    always_comb begin
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            // Sample stands in for the LO, kept off negative full scale
            rmsLo[k] = (mixSample[k] == ADC_NEG_FULL) ?
                       loValue'(ADC_NEG_FULL + 1'b1) : loValue'(mixSample[k]);
            if (useRms) begin
                if (mixUse[k]) begin
                    nextI[k] = mixSample[k] * rmsLo[k];
                end else begin
                    nextI[k] = '0;
                end
                nextQ[k] = '0;
            end else begin
                nextI[k] = mixSample[k] * LO_COS[mixPos];
                nextQ[k] = mixSample[k] * LO_SIN[mixPos];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prodValid <= 1'b0;
        end else if (accept) begin
            prodValid <= 1'b1;
        end else if (prodReady) begin
            prodValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prodI    <= nextI;
            prodQ    <= nextQ;
            prodLast <= (mixPos == turnPos'(`BPM_SAMPLES_PER_TURN - 1));
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gainTrim.sv ====
/*
 * Output stage. Gains are unsigned with one at 2**14 and must only
 * change while the pipeline is empty. Results saturate at full scale.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module gainTrim (
    input  logic             clk,
    input  logic             reset,
    input  logic             magValid,
    input  bpmPkg::magnitude mag [`BPM_CHANNELS],
    input  logic             magOverflow,
    input  bpmPkg::gainValue gain [`BPM_CHANNELS],
    output logic             magReady,
    output logic             outValid,
    output bpmPkg::magnitude outMag [`BPM_CHANNELS],
    output logic             outOverflow,
    input  logic             outReady
);
    import bpmPkg::*;

    localparam int TRIM_WIDTH = `BPM_MAG_WIDTH + `BPM_GAIN_WIDTH;
    localparam int KEEP_TOP   = `BPM_MAG_WIDTH + `BPM_GAIN_FRAC;

    logic [TRIM_WIDTH-1:0] scaled [`BPM_CHANNELS];
    magnitude nextMag [`BPM_CHANNELS];
    logic     clipped;
    logic     accept;

    assign magReady = !outValid || outReady;
    assign accept   = magValid && magReady;

    always_comb begin
        clipped = 1'b0;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            scaled[k] = mag[k] * gain[k];
            // Anything above the kept field means the result is too large
            if (|scaled[k][TRIM_WIDTH-1:KEEP_TOP]) begin
                nextMag[k] = '1;
                clipped = 1'b1;
            end else begin
                nextMag[k] = scaled[k][KEEP_TOP-1:`BPM_GAIN_FRAC];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outMag      <= nextMag;
            outOverflow <= magOverflow | clipped;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/magnitudeEstimator.sv ====
/*
 * Magnitude as max(|I|,|Q|) + min(|I|,|Q|)/2, rounded down.
 * Error against the true magnitude stays within about 12 percent.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module magnitudeEstimator (
    input  logic             clk,
    input  logic             reset,
    input  logic             sumValid,
    input  bpmPkg::turnSum   sumI [`BPM_CHANNELS],
    input  bpmPkg::turnSum   sumQ [`BPM_CHANNELS],
    input  logic             sumOverflow,
    output logic             sumReady,
    output logic             magValid,
    output bpmPkg::magnitude mag [`BPM_CHANNELS],
    output logic             magOverflow,
    input  logic             magReady
);
    import bpmPkg::*;

    magnitude absI [`BPM_CHANNELS];
    magnitude absQ [`BPM_CHANNELS];
    logic [`BPM_MAG_WIDTH:0] estimate [`BPM_CHANNELS];
    magnitude nextMag [`BPM_CHANNELS];
    logic     clipped;
    logic     accept;

    // Absolute value of negative full scale still fits unsigned
    function automatic magnitude absSum(input turnSum value);
        return value[`BPM_MAG_WIDTH-1] ? magnitude'(-value) : magnitude'(value);
    endfunction

    assign sumReady = !magValid || magReady;
    assign accept   = sumValid && sumReady;

    always_comb begin
        clipped = 1'b0;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            absI[k] = absSum(sumI[k]);
            absQ[k] = absSum(sumQ[k]);
            if (absI[k] >= absQ[k]) begin
                estimate[k] = {1'b0, absI[k]} + (absQ[k] >> 1);
            end else begin
                estimate[k] = {1'b0, absQ[k]} + (absI[k] >> 1);
            end
            nextMag[k] = estimate[k][`BPM_MAG_WIDTH] ? '1 : estimate[k][`BPM_MAG_WIDTH-1:0];
            clipped = clipped | estimate[k][`BPM_MAG_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            magValid <= 1'b0;
        end else if (accept) begin
            magValid <= 1'b1;
        end else if (magReady) begin
            magValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mag         <= nextMag;
            magOverflow <= sumOverflow | clipped;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sampleIntake.sv ====
/*
 * Input stage. The first sample accepted after reset is turn position 0,
 * and every accepted transfer advances the position by one.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module sampleIntake (
    input  logic             clk,
    input  logic             reset,
    input  logic             inValid,
    input  bpmPkg::adcSample inSample [`BPM_CHANNELS],
    input  logic             inUse [`BPM_CHANNELS],
    output logic             inReady,
    output logic             mixValid,
    output bpmPkg::adcSample mixSample [`BPM_CHANNELS],
    output logic             mixUse [`BPM_CHANNELS],
    output bpmPkg::turnPos   mixPos,
    input  logic             mixReady
);
    import bpmPkg::*;

    turnPos position;
    logic   accept;

    // Register is free when empty or when its word leaves this cycle
    assign inReady = !mixValid || mixReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            mixValid <= 1'b0;
            position <= '0;
        end else begin
            if (accept) begin
                mixValid <= 1'b1;
                position <= (position == turnPos'(`BPM_SAMPLES_PER_TURN - 1)) ?
                            '0 : position + 1'b1;
            end else if (mixReady) begin
                mixValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mixSample <= inSample;
            mixUse    <= inUse;
            mixPos    <= position;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/turnAccumulator.sv ====
/*
 * Turn accumulator. Non-final products are always taken. A final product
 * waits only while the previous turn result is still unclaimed.
 */
`default_nettype none
`include "bpmSettings_settings.svh"

module turnAccumulator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 prodValid,
    input  bpmPkg::product       prodI [`BPM_CHANNELS],
    input  bpmPkg::product       prodQ [`BPM_CHANNELS],
    input  logic                 prodLast,
    input  bpmPkg::sumShiftValue sumShift,
    output logic                 prodReady,
    output logic                 sumValid,
    output bpmPkg::turnSum       sumI [`BPM_CHANNELS],
    output bpmPkg::turnSum       sumQ [`BPM_CHANNELS],
    output logic                 sumOverflow,
    input  logic                 sumReady
);
    import bpmPkg::*;

    typedef logic signed [`BPM_ACC_WIDTH-1:0] accValue;

    localparam accValue SUM_MAX = accValue'(2 ** (`BPM_MAG_WIDTH - 1) - 1);
    localparam accValue SUM_MIN = -SUM_MAX - 1;

    accValue accI [`BPM_CHANNELS];
    accValue accQ [`BPM_CHANNELS];
    accValue totalI [`BPM_CHANNELS];
    accValue totalQ [`BPM_CHANNELS];
    accValue shiftedI [`BPM_CHANNELS];
    accValue shiftedQ [`BPM_CHANNELS];
    logic    clipped;
    logic    accept;

    function automatic turnSum clampSum(input accValue value);
        if (value > SUM_MAX) begin
            return turnSum'(SUM_MAX);
        end else if (value < SUM_MIN) begin
            return turnSum'(SUM_MIN);
        end
        return turnSum'(value);
    endfunction

    assign prodReady = !prodLast || !sumValid || sumReady;
    assign accept    = prodValid && prodReady;

    //////////////////////////////////////////////////////////////////////
    // Running sums, scaled totals at end of turn

    always_comb begin
        clipped = 1'b0;
        for (int k = 0; k < `BPM_CHANNELS; k++) begin
            totalI[k]   = accI[k] + accValue'(prodI[k]);
            totalQ[k]   = accQ[k] + accValue'(prodQ[k]);
            shiftedI[k] = totalI[k] >>> sumShift;
            shiftedQ[k] = totalQ[k] >>> sumShift;
            if ((shiftedI[k] > SUM_MAX) || (shiftedI[k] < SUM_MIN) ||
                    (shiftedQ[k] > SUM_MAX) || (shiftedQ[k] < SUM_MIN)) begin
                clipped = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sumValid <= 1'b0;
            for (int k = 0; k < `BPM_CHANNELS; k++) begin
                accI[k] <= '0;
                accQ[k] <= '0;
            end
        end else begin
            if (accept) begin
                // Last product of a turn restarts the sums
                for (int k = 0; k < `BPM_CHANNELS; k++) begin
                    accI[k] <= prodLast ? '0 : totalI[k];
                    accQ[k] <= prodLast ? '0 : totalQ[k];
                end
            end
            if (accept && prodLast) begin
                sumValid <= 1'b1;
            end else if (sumReady) begin
                sumValid <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Turn result, held until taken

    always_ff @(posedge clk) begin
        if (accept && prodLast) begin
            for (int k = 0; k < `BPM_CHANNELS; k++) begin
                sumI[k] <= clampSum(shiftedI[k]);
                sumQ[k] <= clampSum(shiftedQ[k]);
            end
            sumOverflow <= clipped;
        end
    end

endmodule

`default_nettype wire
